//--- src.f
+incdir+verilog
verilog/perf_pkg.sv
verilog/commit_classifier.sv
verilog/perf_counter_bank.sv
verilog/csr_perf_port.sv
verilog/perf_unit_top.sv
tests/perf_unit_properties.sv
tests/perf_unit_tb.sv

//--- Makefile
TOOL       = verilator
TOP        = perf_unit_tb
FLIST      = src.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/perf_unit_tb.sv
// performance unit testbench driving a stimulus table against a counter model
`timescale 1ns/1ns
`include "perf_settings.svh"

module perf_unit_tb;
  import perf_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int MAX_STALL  = 7;

  // one table row of stimulus, request, expected err and response stall
  typedef struct packed {
    core_events_t  ev;
    commit_instr_t c0;
    commit_instr_t c1;
    logic [1:0]    ack;
    logic          dbg;
    ctr_addr_t     addr;
    logic          we;
    xlen_t         wdata;
    logic          exp_err;
    int            stall;
    logic          rnd;
  } row_t;

  logic                                      clk_i = 1'b0;
  logic                                      rst_ni;
  logic                                      debug_mode_i;
  core_events_t                              events_i;
  commit_instr_t [`PERF_NR_COMMIT_PORTS-1:0] commit_i;
  logic [`PERF_NR_COMMIT_PORTS-1:0]          commit_ack_i;
  logic                                      req_valid_i;
  logic                                      req_ready_o;
  csr_req_t                                  req_i;
  logic                                      rsp_valid_o;
  logic                                      rsp_ready_i;
  csr_rsp_t                                  rsp_o;

  row_t        rows[$];
  xlen_t       model[`PERF_NR_COUNTERS];
  logic [15:0] lfsr = 16'd24;
  logic        table_ready = 1'b0;
  int          errors = 0;
  int          checks = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  perf_unit_top uut (.*);

  function automatic commit_instr_t instr(input fu_t fu, input op_t op, input int rd);
    return '{fu: fu, op: op, rd: reg_addr_t'(rd)};
  endfunction

  // fibonacci lfsr x^16 + x^14 + x^13 + x^11 stepped once per bit
  function automatic int rand_bits(input int n);
    int v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // err follows the address rule
  function automatic void add_row(input logic [8:0] ev, input commit_instr_t c0,
                                  input commit_instr_t c1, input logic [1:0] ack,
                                  input logic dbg, input int addr, input logic we,
                                  input xlen_t wdata, input int stall, input logic rnd = 1'b0);
    rows.push_back('{core_events_t'(ev), c0, c1, ack, dbg, ctr_addr_t'(addr), we, wdata,
                     addr >= `PERF_NR_COUNTERS, stall, rnd});
  endfunction

  // ------------------------------------------------
  // stimulus table
  // ------------------------------------------------
  function automatic void build_table();
    commit_instr_t nop;
    commit_instr_t ld;
    nop = instr(NONE, OTHER, 0);
    ld  = instr(LOAD, OTHER, 3);
    // all zero after reset
    for (int a = 0; a < `PERF_NR_COUNTERS; a++) begin
      add_row(9'h0, nop, nop, 2'b00, 1'b0, a, 1'b0, '0, 0);
    end
    // one event bit per row
    for (int k = 0; k < 9; k++) begin
      add_row(9'h1 << k, nop, nop, 2'b00, 1'b0, k, 1'b0, '0, 1);
    end
    // commit classes where two loads add two
    add_row(9'h0, ld, ld, 2'b11, 1'b0, CTR_LOAD, 1'b0, '0, 0);
    add_row(9'h0, instr(STORE, OTHER, 0), instr(CTRL_FLOW, ADD, 1), 2'b11, 1'b0, CTR_CALL,
            1'b0, '0, 2);
    add_row(9'h0, instr(CTRL_FLOW, JALR, 0), instr(CTRL_FLOW, JALR, 5), 2'b11, 1'b0, CTR_RET,
            1'b0, '0, 0);
    // port 1 not acked and rd 2 is no link register
    add_row(9'h0, instr(CTRL_FLOW, ADD, 2), ld, 2'b01, 1'b0, CTR_BRANCH_JUMP, 1'b0, '0, 0);
    add_row(9'h0, ld, instr(STORE, OTHER, 7), 2'b00, 1'b0, CTR_LOAD, 1'b0, '0, 0);
    // debug freeze still lets a write land
    add_row(9'h1ff, ld, ld, 2'b11, 1'b1, CTR_LOAD, 1'b0, '0, 0);
    add_row(9'h1ff, ld, ld, 2'b11, 1'b1, CTR_STORE, 1'b1, 64'h1234, 0);
    // write against increment of the same edge
    add_row(9'h080, nop, nop, 2'b00, 1'b0, CTR_DCACHE_MISS, 1'b1, 64'hdead_beef_0000_0001, 1);
    add_row(9'h0, ld, ld, 2'b11, 1'b0, CTR_LOAD, 1'b1, 64'h55, 0);
    // unmapped addresses under back-pressure
    add_row(9'h1ff, nop, nop, 2'b00, 1'b0, 14, 1'b0, '0, 3);
    add_row(9'h0, nop, nop, 2'b00, 1'b0, 31, 1'b1, 64'hffff, 5);
    // random events and stalls
    for (int k = 0; k < 8; k++) begin
      add_row(9'h0, ld, instr(CTRL_FLOW, JALR, 1), 2'b10, 1'b0, k + 5, 1'b0, '0, 0, 1'b1);
    end
    // final sweep catches counts landing in the wrong slot
    for (int a = 0; a < `PERF_NR_COUNTERS; a++) begin
      add_row(9'h0, nop, nop, 2'b00, 1'b0, a, 1'b0, '0, 0);
    end
  endfunction

  // reference counters following the counting rules of the unit
  task automatic update_model(input row_t r, input core_events_t ev);
    commit_instr_t c;
    if (!r.dbg) begin
      model[CTR_ICACHE_MISS]   += xlen_t'(ev.icache_miss);
      model[CTR_DCACHE_MISS]   += xlen_t'(ev.dcache_miss);
      model[CTR_ITLB_MISS]     += xlen_t'(ev.itlb_miss);
      model[CTR_DTLB_MISS]     += xlen_t'(ev.dtlb_miss);
      model[CTR_EXCEPTION]     += xlen_t'(ev.exception);
      model[CTR_EXCEPTION_RET] += xlen_t'(ev.eret);
      model[CTR_MISPREDICT]    += xlen_t'(ev.mispredict);
      model[CTR_SB_FULL]       += xlen_t'(ev.sb_full);
      model[CTR_IF_EMPTY]      += xlen_t'(ev.if_empty);
      for (int p = 0; p < 2; p++) begin
        c = (p == 0) ? r.c0 : r.c1;
        if (r.ack[p]) begin
          model[CTR_LOAD]        += xlen_t'(c.fu == LOAD);
          model[CTR_STORE]       += xlen_t'(c.fu == STORE);
          model[CTR_BRANCH_JUMP] += xlen_t'(c.fu == CTRL_FLOW);
          model[CTR_CALL] += xlen_t'(((c.fu == CTRL_FLOW && c.op == ADD) || c.op == JALR) &&
                                     (c.rd == 5'd1 || c.rd == 5'd5));
          model[CTR_RET]         += xlen_t'(c.op == JALR && c.rd == 5'd0);
        end
      end
    end
    // write replaces the increment
    if (r.we && !r.exp_err) begin
      model[r.addr] = r.wdata;
    end
  endtask

  task automatic check_rsp(input xlen_t exp_rdata, input logic exp_err);
    checks++;
    if (!rsp_valid_o) begin
      errors++;
      $display("%0t response missing while it should be held", $time);
    end else if (rsp_o.rdata !== exp_rdata) begin
      errors++;
      $display("[ERROR] %0t rsp_o.rdata expected %h got %h", $time, exp_rdata, rsp_o.rdata);
    end else if (rsp_o.err !== exp_err) begin
      errors++;
      $display("[ERROR] %0t rsp_o.err expected %b got %b", $time, exp_err, rsp_o.err);
    end
  endtask

  task automatic check_ready(input logic exp_ready);
    checks++;
    if (req_ready_o !== exp_ready) begin
      errors++;
      $display("[ERROR] %0t req_ready_o expected %b got %b", $time, exp_ready, req_ready_o);
    end
  endtask

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------
  initial begin
    row_t         r;
    core_events_t ev;
    int           stall;
    int           row_errors;
    xlen_t        exp_rdata;
    rst_ni       = 1'b0;
    debug_mode_i = 1'b0;
    events_i     = '0;
    commit_i     = '0;
    commit_ack_i = '0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    rsp_ready_i  = 1'b0;
    foreach (model[i]) begin
      model[i] = '0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    foreach (rows[i]) begin
      r          = rows[i];
      ev         = r.ev;
      stall      = r.stall;
      row_errors = errors;
      if (r.rnd) begin
        ev    = core_events_t'(9'(rand_bits(9)));
        stall = rand_bits(3);
      end
      events_i     = ev;
      commit_i     = {r.c1, r.c0};
      commit_ack_i = r.ack;
      debug_mode_i = r.dbg;
      req_valid_i  = 1'b1;
      req_i        = '{addr: r.addr, we: r.we, wdata: r.wdata};
      @(negedge clk_i);
      check_ready(1'b1);
      @(posedge clk_i);
      // read sees the value from before this edge
      exp_rdata = r.exp_err ? '0 : model[r.addr];
      update_model(r, ev);
      #1;
      events_i     = '0;
      commit_ack_i = '0;
      debug_mode_i = 1'b0;
      req_valid_i  = 1'b0;
      // hold the response back for the stall count
      repeat (stall) begin
        @(negedge clk_i);
        check_rsp(exp_rdata, r.exp_err);
        // held response closes the request side
        check_ready(1'b0);
        @(posedge clk_i);
      end
      #1 rsp_ready_i = 1'b1;
      @(negedge clk_i);
      check_rsp(exp_rdata, r.exp_err);
      // taking the response reopens it in the same cycle
      check_ready(1'b1);
      @(posedge clk_i);
      #1 rsp_ready_i = 1'b0;
      @(negedge clk_i);
      if (rsp_valid_o) begin
        errors++;
        $display("row %0d: response delivered twice", i);
      end
      @(posedge clk_i);
      #1;
      $display("row %0d addr %0d stall %0d: %s", i, r.addr, stall,
               (errors == row_errors) ? "ok" : "failed");
    end
    $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // reset plus worst case per row plus margin
  initial begin
    wait (table_ready);
    #((10 + rows.size() * (MAX_STALL + 4) + 20) * CLK_PERIOD);
    $display("watchdog expired before the last row finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- tests/perf_unit_properties.sv
// performance unit properties: response back-pressure and reset state checks
`timescale 1ns/1ns

module perf_unit_properties (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               req_ready_o,
  input logic               rsp_valid_o,
  input logic               rsp_ready_i,
  input perf_pkg::csr_rsp_t rsp_o
);

  // ------------------------------------------------
  // response channel
  // ------------------------------------------------
  // held response keeps valid and payload until taken
  rsp_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else $error("response changed or dropped while stalled");

  // ------------------------------------------------
  // reset state
  // ------------------------------------------------
  ready_after_reset_a : assert property (@(posedge clk_i) $rose(rst_ni) |-> req_ready_o)
    else $error("req_ready_o low right after reset");

  // no response may leave the unit in reset
  no_rsp_in_reset_a : assert property (@(posedge clk_i) !rst_ni |-> !rsp_valid_o)
    else $error("rsp_valid_o high during reset");

endmodule

bind perf_unit_top perf_unit_properties i_props (.*);

//--- verilog/perf_unit_top.sv
// performance unit top: commit classifier, counter bank and csr front end
`timescale 1ns/1ns
`include "perf_settings.svh"

module perf_unit_top (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              debug_mode_i,
  // single-bit core events
  input  perf_pkg::core_events_t                            events_i,
  // commit stage
  input  perf_pkg::commit_instr_t [`PERF_NR_COMMIT_PORTS-1:0] commit_i,
  input  logic [`PERF_NR_COMMIT_PORTS-1:0]                  commit_ack_i,
  // csr request
  input  logic                                              req_valid_i,
  output logic                                              req_ready_o,
  input  perf_pkg::csr_req_t                                req_i,
  // csr response
  output logic                                              rsp_valid_o,
  input  logic                                              rsp_ready_i,
  output perf_pkg::csr_rsp_t                                rsp_o
);
  import perf_pkg::*;

  // ------------------------------------------------
  // internal wires
  // ------------------------------------------------
  commit_counts_t counts;
  logic           access;
  logic           we;
  ctr_addr_t      addr;
  xlen_t          wdata;
  xlen_t          rdata;

  // commit decode, same cycle
  commit_classifier i_classifier (
    .commit_i (commit_i),
    .ack_i    (commit_ack_i),
    .counts_o (counts)
  );

  perf_counter_bank i_bank (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .debug_mode_i (debug_mode_i),
    .events_i     (events_i),
    .counts_i     (counts),
    .access_i     (access),
    .we_i         (we),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .rdata_o      (rdata)
  );

  // software access path
  csr_perf_port i_csr_port (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o),
    .access_o    (access),
    .we_o        (we),
    .addr_o      (addr),
    .wdata_o     (wdata),
    .rdata_i     (rdata)
  );

endmodule

//--- verilog/csr_perf_port.sv
// csr front end: valid/ready request, range check and one-cycle registered response
`timescale 1ns/1ns
`include "perf_settings.svh"

module csr_perf_port (
  input  logic               clk_i,
  input  logic               rst_ni,
  // request channel
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  perf_pkg::csr_req_t req_i,
  // response channel
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  output perf_pkg::csr_rsp_t rsp_o,
  // towards the counter bank
  output logic               access_o,
  output logic               we_o,
  output perf_pkg::ctr_addr_t addr_o,
  output perf_pkg::xlen_t    wdata_o,
  input  perf_pkg::xlen_t    rdata_i
);
  import perf_pkg::*;

  logic     in_range;
  logic     rsp_valid_q;
  csr_rsp_t rsp_q;

  // the one range check of the design
  assign in_range = req_i.addr < ctr_addr_t'(`PERF_NR_COUNTERS);

  // free slot, or the held response leaves this cycle
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;

  // ------------------------------------------------
  // bank access
  // ------------------------------------------------
  assign access_o = req_valid_i && req_ready_o;
  // no write to unmapped slots
  assign we_o     = req_i.we && in_range;
  assign addr_o   = req_i.addr;
  assign wdata_o  = req_i.wdata;

  // ------------------------------------------------
  // response register
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (access_o) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // payload only moves on accept, stays put under back-pressure
  always_ff @(posedge clk_i) begin
    if (access_o) begin
      rsp_q.rdata <= in_range ? rdata_i : '0;
      rsp_q.err   <= !in_range;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

//--- verilog/perf_counter_bank.sv
// performance counter bank: event increments, debug freeze and write-after-read access
`timescale 1ns/1ns
`include "perf_settings.svh"

module perf_counter_bank (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // freezes counting, not writes
  input  logic                     debug_mode_i,
  input  perf_pkg::core_events_t   events_i,
  input  perf_pkg::commit_counts_t counts_i,
  // single-cycle access from the csr port
  input  logic                     access_i,
  input  logic                     we_i,
  input  perf_pkg::ctr_addr_t      addr_i,
  input  perf_pkg::xlen_t          wdata_i,
  // current value of the addressed counter
  output perf_pkg::xlen_t          rdata_o
);
  import perf_pkg::*;

  xlen_t [`PERF_NR_COUNTERS-1:0] ctr_q;
  xlen_t [`PERF_NR_COUNTERS-1:0] ctr_d;

  // ------------------------------------------------
  // next counter values
  // ------------------------------------------------
  always_comb begin
    ctr_d = ctr_q;

    if (!debug_mode_i) begin
      // memory system misses
      ctr_d[CTR_ICACHE_MISS] = ctr_q[CTR_ICACHE_MISS] + xlen_t'(events_i.icache_miss);
      ctr_d[CTR_DCACHE_MISS] = ctr_q[CTR_DCACHE_MISS] + xlen_t'(events_i.dcache_miss);
      ctr_d[CTR_ITLB_MISS]   = ctr_q[CTR_ITLB_MISS] + xlen_t'(events_i.itlb_miss);
      ctr_d[CTR_DTLB_MISS]   = ctr_q[CTR_DTLB_MISS] + xlen_t'(events_i.dtlb_miss);

      // commit classes add the whole cycle count
      ctr_d[CTR_LOAD]        = ctr_q[CTR_LOAD] + xlen_t'(counts_i.load);
      ctr_d[CTR_STORE]       = ctr_q[CTR_STORE] + xlen_t'(counts_i.store);
      ctr_d[CTR_BRANCH_JUMP] = ctr_q[CTR_BRANCH_JUMP] + xlen_t'(counts_i.branch);
      ctr_d[CTR_CALL]        = ctr_q[CTR_CALL] + xlen_t'(counts_i.call);
      ctr_d[CTR_RET]         = ctr_q[CTR_RET] + xlen_t'(counts_i.ret);

      // traps and frontend
      ctr_d[CTR_EXCEPTION]     = ctr_q[CTR_EXCEPTION] + xlen_t'(events_i.exception);
      ctr_d[CTR_EXCEPTION_RET] = ctr_q[CTR_EXCEPTION_RET] + xlen_t'(events_i.eret);
      ctr_d[CTR_MISPREDICT]    = ctr_q[CTR_MISPREDICT] + xlen_t'(events_i.mispredict);

      // stall cycles
      ctr_d[CTR_SB_FULL]  = ctr_q[CTR_SB_FULL] + xlen_t'(events_i.sb_full);
      ctr_d[CTR_IF_EMPTY] = ctr_q[CTR_IF_EMPTY] + xlen_t'(events_i.if_empty);
    end

    // write last, so it beats the increment of the same cycle
    for (int unsigned i = 0; i < `PERF_NR_COUNTERS; i++) begin
      if (access_i && we_i && addr_i == ctr_addr_t'(i)) begin
        ctr_d[i] = wdata_i;
      end
    end
  end

  // ------------------------------------------------
  // read mux
  // ------------------------------------------------
  // old value, write-after-read
  // unmapped slots read zero
  always_comb begin
    rdata_o = '0;
    for (int unsigned i = 0; i < `PERF_NR_COUNTERS; i++) begin
      if (addr_i == ctr_addr_t'(i)) begin
        rdata_o = ctr_q[i];
      end
    end
  end

  // ------------------------------------------------
  // registers
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q <= '0;
    end else begin
      ctr_q <= ctr_d;
    end
  end

endmodule

//--- verilog/commit_classifier.sv
// commit classifier: counts acknowledged commits per instruction class in one cycle
`timescale 1ns/1ns
`include "perf_settings.svh"

module commit_classifier (
  // instructions on the commit ports
  input  perf_pkg::commit_instr_t [`PERF_NR_COMMIT_PORTS-1:0] commit_i,
  // port really commits this cycle
  input  logic [`PERF_NR_COMMIT_PORTS-1:0]                    ack_i,
  // per-class totals for the cycle
  output perf_pkg::commit_counts_t                            counts_o
);
  import perf_pkg::*;

  // x1 and x5 are the link registers of the calling convention
  function automatic logic is_link(input reg_addr_t rd);
    return (rd == reg_addr_t'(1)) || (rd == reg_addr_t'(5));
  endfunction

  // ------------------------------------------------
  // per-port decode, summed over ports
  // ------------------------------------------------
  always_comb begin
    counts_o = '0;
    for (int unsigned i = 0; i < `PERF_NR_COMMIT_PORTS; i++) begin
      // unacked ports drop out here
      if (ack_i[i]) begin
        if (commit_i[i].fu == LOAD) begin
          counts_o.load = counts_o.load + 1'b1;
        end
        if (commit_i[i].fu == STORE) begin
          counts_o.store = counts_o.store + 1'b1;
        end
        // every control flow op, taken or not
        if (commit_i[i].fu == CTRL_FLOW) begin
          counts_o.branch = counts_o.branch + 1'b1;
        end
        // jal or jalr writing a link register
        if ((commit_i[i].fu == CTRL_FLOW && commit_i[i].op == ADD &&
             is_link(commit_i[i].rd)) ||
            (commit_i[i].op == JALR && is_link(commit_i[i].rd))) begin
          counts_o.call = counts_o.call + 1'b1;
        end
        // jalr discarding the link, i.e. ret
        if (commit_i[i].op == JALR && commit_i[i].rd == reg_addr_t'(0)) begin
          counts_o.ret = counts_o.ret + 1'b1;
        end
      end
    end
  end

endmodule

//--- verilog/perf_pkg.sv
// performance unit package: shared vector types, enums and packed structs
`include "perf_settings.svh"

package perf_pkg;

  // ------------------------------------------------
  // plain vectors
  // ------------------------------------------------
  typedef logic [`PERF_XLEN-1:0]   xlen_t;
  typedef logic [`PERF_ADDR_W-1:0] ctr_addr_t;
  typedef logic [4:0]              reg_addr_t;
  // per-class commit count, 0 up to all ports
  typedef logic [$clog2(`PERF_NR_COMMIT_PORTS+1)-1:0] commit_cnt_t;

  // ------------------------------------------------
  // enums
  // ------------------------------------------------
  typedef enum logic [2:0] {NONE, LOAD, STORE, ALU, CTRL_FLOW} fu_t;
  // jal is decoded as add
  typedef enum logic [1:0] {ADD, JALR, OTHER} op_t;

  // counter slot of every event
  typedef enum logic [`PERF_ADDR_W-1:0] {
    CTR_ICACHE_MISS, CTR_DCACHE_MISS, CTR_ITLB_MISS, CTR_DTLB_MISS,
    CTR_LOAD, CTR_STORE, CTR_BRANCH_JUMP, CTR_CALL, CTR_RET,
    CTR_EXCEPTION, CTR_EXCEPTION_RET, CTR_MISPREDICT, CTR_SB_FULL, CTR_IF_EMPTY
  } ctr_idx_e;

  // ------------------------------------------------
  // structs
  // ------------------------------------------------
  typedef struct packed {
    fu_t       fu;
    op_t       op;
    reg_addr_t rd;
  } commit_instr_t;

  // one-bit events, one cycle each
  typedef struct packed {
    logic icache_miss;
    logic dcache_miss;
    logic itlb_miss;
    logic dtlb_miss;
    logic exception;
    logic eret;
    logic mispredict;
    logic sb_full;
    logic if_empty;
  } core_events_t;

  typedef struct packed {
    commit_cnt_t load;
    commit_cnt_t store;
    commit_cnt_t branch;
    commit_cnt_t call;
    commit_cnt_t ret;
  } commit_counts_t;

  typedef struct packed {
    ctr_addr_t addr;
    logic      we;
    xlen_t     wdata;
  } csr_req_t;

  typedef struct packed {
    xlen_t rdata;
    logic  err;
  } csr_rsp_t;

endpackage

//--- verilog/perf_settings.svh
// performance unit settings: data width, commit ports, counter count, address width
`ifndef PERF_SETTINGS_SVH
`define PERF_SETTINGS_SVH

// ------------------------------------------------
// datapath
// ------------------------------------------------
// counter and csr data width
`define PERF_XLEN 64

// commit ports coming from the core
`define PERF_NR_COMMIT_PORTS 2

// ------------------------------------------------
// counter space
// ------------------------------------------------
// implemented counters, addresses 0 .. 13
`define PERF_NR_COUNTERS 14
// csr counter address width, room for 32 slots
`define PERF_ADDR_W 5

`endif
